// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f dac_tx.f \
		--top-module dac_tx_tb -Mdir obj_dir -o dac_tx_sim
	-./obj_dir/dac_tx_sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "test failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "test passed" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// File: dac_tx.f
design/dac_tx_pkg.sv
design/dac_cfg_if.sv
design/dac_ctrl_decode.sv
design/dac_sample_cond.sv
design/dac_ddr_serializer.sv
design/dac_tx_top.sv
dv/dac_tx_assert.sv
dv/dac_tx_tb.sv

// File: design/dac_cfg_if.sv
`default_nettype none

interface dac_cfg_if
   import dac_tx_pkg::*;
#(
   parameter int SAMPLE_WIDTH = SAMPLE_W
)
();

   // Sample conditioning controls
   logic                    swap;
   logic                    neg_i;
   logic                    neg_q;
   logic                    test_en;
   // Constant pattern used when test_en is set
   logic [SAMPLE_WIDTH-1:0] test_i;
   logic [SAMPLE_WIDTH-1:0] test_q;
   // One 1x cycle pulse, starts a DAC frame-sync sequence
   logic                    sync_stb;

   // Register decoder owns every field
   modport ctrl
   (
      output swap, neg_i, neg_q, test_en, test_i, test_q, sync_stb
   );

   // Conditioner only needs the data path controls
   modport cond
   (
      input swap, neg_i, neg_q, test_en, test_i, test_q
   );

   // Serializer only sees the sync command
   modport ser
   (
      input sync_stb
   );

endinterface

`default_nettype wire

// File: design/dac_ctrl_decode.sv
`default_nettype none

module dac_ctrl_decode
   import dac_tx_pkg::*;
#(
   parameter int SAMPLE_WIDTH = SAMPLE_W
)
(
   input  wire                      tx_clk_1x,
   input  wire                      reset,
   // Single cycle write strobe, no back-pressure
   input  wire                      i_wr_stb,
   input  wire [ADDR_W-1:0]         i_wr_addr,
   input  wire [2*SAMPLE_WIDTH-1:0] i_wr_data,
   // Configuration toward conditioner and serializer
   dac_cfg_if.ctrl                  cfg
);

   // Address decode
   logic                    wr_ctrl;
   logic                    wr_test;
   logic                    wr_sync;

   // Holding registers
   logic [3:0]              ctrl_reg;
   logic [SAMPLE_WIDTH-1:0] test_i_reg;
   logic [SAMPLE_WIDTH-1:0] test_q_reg;
   logic                    sync_reg;

   // Unknown addresses match none of these and are dropped
   assign wr_ctrl = i_wr_stb && (i_wr_addr == REG_CTRL);
   assign wr_test = i_wr_stb && (i_wr_addr == REG_TEST);
   assign wr_sync = i_wr_stb && (i_wr_addr == REG_SYNC);

   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         ctrl_reg   <= '0;
         test_i_reg <= '0;
         test_q_reg <= '0;
         sync_reg   <= 1'b0;
      end
      else
      begin
         // Control bits live in the bottom nibble
         if (wr_ctrl)
         begin
            ctrl_reg <= i_wr_data[3:0];
         end
         // Low half is I, high half is Q
         if (wr_test)
         begin
            test_i_reg <= i_wr_data[SAMPLE_WIDTH-1:0];
            test_q_reg <= i_wr_data[2*SAMPLE_WIDTH-1:SAMPLE_WIDTH];
         end
         // Any write to the sync address gives exactly one pulse
         sync_reg <= wr_sync;
      end
   end

   // Fan the control bits out by name
   assign cfg.swap    = ctrl_reg[CTRL_SWAP];
   assign cfg.neg_i   = ctrl_reg[CTRL_NEG_I];
   assign cfg.neg_q   = ctrl_reg[CTRL_NEG_Q];
   assign cfg.test_en = ctrl_reg[CTRL_TEST_EN];

   // Test pattern straight from the holding registers
   assign cfg.test_i  = test_i_reg;
   assign cfg.test_q  = test_q_reg;

   // Pulse is high the cycle after the strobe
   assign cfg.sync_stb = sync_reg;

endmodule

`default_nettype wire

// File: design/dac_ddr_serializer.sv
`default_nettype none

module dac_ddr_serializer
   import dac_tx_pkg::*;
#(
   parameter int SAMPLE_WIDTH = SAMPLE_W
)
(
   input  wire                       tx_clk_1x,
   input  wire                       tx_clk_2x,
   // Synchronous to tx_clk_1x
   input  wire                       reset,
   // Conditioned pair, new value every 1x cycle
   input  wire [SAMPLE_WIDTH-1:0]    i_i,
   input  wire [SAMPLE_WIDTH-1:0]    i_q,
   // Frame-sync command from the decoder
   dac_cfg_if.ser                    cfg,
   // Forwarded source-synchronous clock
   output logic                      o_clk_p,
   output logic                      o_clk_n,
   // High during I words
   output logic                      o_frame_p,
   output logic                      o_frame_n,
   // Byte lane, high byte then low byte in each 2x cycle
   output logic [SAMPLE_WIDTH/2-1:0] o_d_p,
   output logic [SAMPLE_WIDTH/2-1:0] o_d_n
);

   localparam int LANE_WIDTH = SAMPLE_WIDTH / 2;

   // 1x domain
   logic                    phase;
   logic [SAMPLE_WIDTH-1:0] i_reg;
   logic [SAMPLE_WIDTH-1:0] q_reg;

   // 2x domain
   logic                    reset_2x;
   logic [SAMPLE_WIDTH-1:0] i_2x;
   logic [SAMPLE_WIDTH-1:0] q_2x;
   logic                    phase_2x;
   logic                    boundary;
   logic                    sync_2x;
   logic                    q_slot;
   logic [SAMPLE_WIDTH-1:0] word_2x;

   // Output stage
   logic [LANE_WIDTH-1:0]   d_hi;
   logic [LANE_WIDTH-1:0]   d_lo;
   logic                    frame_2x;
   logic [LANE_WIDTH-1:0]   ddr_d;
   logic                    ddr_frame;
   logic                    ddr_clk;

   // Toggles every 1x cycle so the 2x side can find the 1x edge
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         phase <= 1'b0;
      end
      else
      begin
         phase <= ~phase;
      end
   end

   // Input pipeline, nothing but flops in front of the domain crossing
   always_ff @(posedge tx_clk_1x)
   begin
      i_reg <= i_i;
      q_reg <= i_q;
   end

   // Move data and phase into the 2x domain
   always_ff @(posedge tx_clk_2x)
   begin
      reset_2x <= reset;
      i_2x     <= i_reg;
      q_2x     <= q_reg;
      phase_2x <= phase;
   end

   // Equal only in the second half of each 1x period
   assign boundary = (phase == phase_2x);

   // Sync flag and slot select
   // sync_stb is seen for two 2x cycles, the clear wins on the boundary
   always_ff @(posedge tx_clk_2x)
   begin
      if (reset_2x)
      begin
         sync_2x <= 1'b0;
         q_slot  <= 1'b0;
      end
      else
      begin
         if (boundary && sync_2x)
         begin
            sync_2x <= 1'b0;
         end
         else if (cfg.sync_stb)
         begin
            sync_2x <= 1'b1;
         end
         // A pending sync squashes one Q slot, so frame stays high 3 words
         q_slot <= boundary && !sync_2x;
      end
   end

   // Interleave I and Q at the 2x rate
   assign word_2x = q_slot ? q_2x : i_2x;

   // Same-edge DDR capture, both halves registered on the rising edge
   always_ff @(posedge tx_clk_2x)
   begin
      if (reset_2x)
      begin
         d_hi     <= '0;
         d_lo     <= '0;
         frame_2x <= 1'b0;
      end
      else
      begin
         d_hi     <= word_2x[SAMPLE_WIDTH-1 -: LANE_WIDTH];
         d_lo     <= word_2x[LANE_WIDTH-1:0];
         frame_2x <= !q_slot;
      end
   end

   // High byte while the clock is high, low byte while it is low
   assign ddr_d     = tx_clk_2x ? d_hi : d_lo;
   // Frame holds its value over both halves
   assign ddr_frame = frame_2x;
   // Forwarded clock, a 1 then 0 pattern follows the 2x clock level
   assign ddr_clk   = tx_clk_2x;

   // Differential pins, true and complement
   assign o_d_p     = ddr_d;
   assign o_d_n     = ~ddr_d;
   assign o_frame_p = ddr_frame;
   assign o_frame_n = ~ddr_frame;
   assign o_clk_p   = ddr_clk;
   assign o_clk_n   = ~ddr_clk;

endmodule

`default_nettype wire

// File: design/dac_sample_cond.sv
`default_nettype none

module dac_sample_cond
   import dac_tx_pkg::*;
#(
   parameter int SAMPLE_WIDTH = SAMPLE_W
)
(
   input  wire                     tx_clk_1x,
   input  wire                     reset,
   // Raw I/Q pair, one per 1x cycle
   input  wire [SAMPLE_WIDTH-1:0]  i_i,
   input  wire [SAMPLE_WIDTH-1:0]  i_q,
   // Conditioning controls from the register decoder
   dac_cfg_if.cond                 cfg,
   // Conditioned pair, one cycle later
   output logic [SAMPLE_WIDTH-1:0] o_i,
   output logic [SAMPLE_WIDTH-1:0] o_q
);

   // After test substitution
   logic [SAMPLE_WIDTH-1:0] src_i;
   logic [SAMPLE_WIDTH-1:0] src_q;
   // After swap
   logic [SAMPLE_WIDTH-1:0] swp_i;
   logic [SAMPLE_WIDTH-1:0] swp_q;
   // After negation
   logic [SAMPLE_WIDTH-1:0] cnd_i;
   logic [SAMPLE_WIDTH-1:0] cnd_q;

   // Two's complement negate
   // The most negative code wraps back onto itself
   function automatic logic [SAMPLE_WIDTH-1:0] negate(input logic [SAMPLE_WIDTH-1:0] x);
      return ~x + 1'b1;
   endfunction

   always_comb
   begin
      // Test pattern overrides both channels
      src_i = cfg.test_en ? cfg.test_i : i_i;
      src_q = cfg.test_en ? cfg.test_q : i_q;

      // Swap works on the substituted values
      swp_i = cfg.swap ? src_q : src_i;
      swp_q = cfg.swap ? src_i : src_q;

      // Negation is applied per output channel
      cnd_i = cfg.neg_i ? negate(swp_i) : swp_i;
      cnd_q = cfg.neg_q ? negate(swp_q) : swp_q;
   end

   // Output register, one cycle of latency
   always_ff @(posedge tx_clk_1x)
   begin
      if (reset)
      begin
         o_i <= '0;
         o_q <= '0;
      end
      else
      begin
         o_i <= cnd_i;
         o_q <= cnd_q;
      end
   end

endmodule

`default_nettype wire

// File: design/dac_tx_pkg.sv
`default_nettype none

package dac_tx_pkg;

   // Width of one I or Q sample
   localparam int SAMPLE_W = 16;

   // Width of the DDR byte lane toward the DAC
   localparam int LANE_W = 8;

   // Register address width on the write port
   localparam int ADDR_W = 4;

   // Register map
   // Control bits, see ctrl_bit_e for the layout
   localparam logic [ADDR_W-1:0] REG_CTRL = 4'h0;
   // Test pattern, I in the low half, Q in the high half
   localparam logic [ADDR_W-1:0] REG_TEST = 4'h1;
   // Sync command, data is ignored
   localparam logic [ADDR_W-1:0] REG_SYNC = 4'h2;

   // Bit positions inside the control register
   typedef enum logic [1:0]
   {
      // Exchange I and Q
      CTRL_SWAP    = 2'd0,
      // Negate the I channel after the swap
      CTRL_NEG_I   = 2'd1,
      // Negate the Q channel after the swap
      CTRL_NEG_Q   = 2'd2,
      // Replace both inputs with the test pattern
      CTRL_TEST_EN = 2'd3
   } ctrl_bit_e;

endpackage

`default_nettype wire

// File: design/dac_tx_top.sv
`default_nettype none

module dac_tx_top
   import dac_tx_pkg::*;
#(
   parameter int SAMPLE_WIDTH = SAMPLE_W
)
(
   input  wire                       tx_clk_1x,
   input  wire                       tx_clk_2x,
   input  wire                       reset,
   // Register write port, 1x domain
   input  wire                       i_wr_stb,
   input  wire [ADDR_W-1:0]          i_wr_addr,
   input  wire [2*SAMPLE_WIDTH-1:0]  i_wr_data,
   // Sample stream, one pair per 1x cycle
   input  wire [SAMPLE_WIDTH-1:0]    i_i,
   input  wire [SAMPLE_WIDTH-1:0]    i_q,
   // LVDS toward the DAC
   output logic                      o_tx_clk_p,
   output logic                      o_tx_clk_n,
   output logic                      o_tx_frame_p,
   output logic                      o_tx_frame_n,
   output logic [SAMPLE_WIDTH/2-1:0] o_tx_d_p,
   output logic [SAMPLE_WIDTH/2-1:0] o_tx_d_n
);

   // Conditioned pair between conditioner and serializer
   logic [SAMPLE_WIDTH-1:0] cond_i;
   logic [SAMPLE_WIDTH-1:0] cond_q;

   // Configuration bundle
   dac_cfg_if #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) u_cfg ();

   // Register decode
   dac_ctrl_decode #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) u_decode
   (
      .tx_clk_1x (tx_clk_1x),
      .reset     (reset),
      .i_wr_stb  (i_wr_stb),
      .i_wr_addr (i_wr_addr),
      .i_wr_data (i_wr_data),
      .cfg       (u_cfg.ctrl)
   );

   // Swap, negate, test pattern
   dac_sample_cond #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) u_cond
   (
      .tx_clk_1x (tx_clk_1x),
      .reset     (reset),
      .i_i       (i_i),
      .i_q       (i_q),
      .cfg       (u_cfg.cond),
      .o_i       (cond_i),
      .o_q       (cond_q)
   );

   // 1x to 2x transfer and DDR pins
   dac_ddr_serializer #(.SAMPLE_WIDTH(SAMPLE_WIDTH)) u_ser
   (
      .tx_clk_1x (tx_clk_1x),
      .tx_clk_2x (tx_clk_2x),
      .reset     (reset),
      .i_i       (cond_i),
      .i_q       (cond_q),
      .cfg       (u_cfg.ser),
      .o_clk_p   (o_tx_clk_p),
      .o_clk_n   (o_tx_clk_n),
      .o_frame_p (o_tx_frame_p),
      .o_frame_n (o_tx_frame_n),
      .o_d_p     (o_tx_d_p),
      .o_d_n     (o_tx_d_n)
   );

endmodule

`default_nettype wire

// File: dv/dac_tx_assert.sv
`default_nettype none

module dac_tx_assert
#(
   parameter int LANE_WIDTH = 8
)
(
   input wire                  tx_clk_2x,
   input wire                  reset,
   input wire                  o_clk_p,
   input wire                  o_clk_n,
   input wire                  o_frame_p,
   input wire                  o_frame_n,
   input wire [LANE_WIDTH-1:0] o_d_p,
   input wire [LANE_WIDTH-1:0] o_d_n
);

   // Every pin pair is true and complement
   a_d_diff : assert property (@(posedge tx_clk_2x) disable iff (reset) o_d_n == ~o_d_p)
      else $error("data pins not complementary");
   a_frame_diff : assert property (@(posedge tx_clk_2x) disable iff (reset)
      o_frame_n == ~o_frame_p)
      else $error("frame pins not complementary");
   a_clk_diff : assert property (@(negedge tx_clk_2x) disable iff (reset) o_clk_n == ~o_clk_p)
      else $error("clock pins not complementary");

   // Forwarded clock is low just before each rise and high just before each fall
   a_clk_rise : assert property (@(posedge tx_clk_2x) disable iff (reset) !o_clk_p)
      else $error("forwarded clock missed a low half");
   a_clk_fall : assert property (@(negedge tx_clk_2x) disable iff (reset) o_clk_p)
      else $error("forwarded clock missed a high half");

endmodule

bind dac_ddr_serializer dac_tx_assert #(.LANE_WIDTH(SAMPLE_WIDTH/2)) u_assert
(
   .tx_clk_2x (tx_clk_2x),
   .reset     (reset),
   .o_clk_p   (o_clk_p),
   .o_clk_n   (o_clk_n),
   .o_frame_p (o_frame_p),
   .o_frame_n (o_frame_n),
   .o_d_p     (o_d_p),
   .o_d_n     (o_d_n)
);

`default_nettype wire

// File: dv/dac_tx_tb.sv
`default_nettype none

module dac_tx_tb
   import dac_tx_pkg::*;
;
   localparam int NCASE = 9;

   logic        tx_clk_1x = 1'b0;
   logic        tx_clk_2x = 1'b0;
   logic        reset = 1'b1;
   logic        i_wr_stb = 1'b0;
   logic [3:0]  i_wr_addr = '0;
   logic [31:0] i_wr_data = '0;
   logic [15:0] i_i = '0;
   logic [15:0] i_q = '0;
   logic        o_tx_clk_p;
   logic        o_tx_clk_n;
   logic        o_tx_frame_p;
   logic        o_tx_frame_n;
   logic [7:0]  o_tx_d_p;
   logic [7:0]  o_tx_d_n;

   // Stimulus table
   string       tname [NCASE];
   logic [3:0]  tctrl [NCASE];
   logic [31:0] tpat  [NCASE];
   logic        tsync [NCASE];
   int          tcount[NCASE];

   string       cur_name = "reset";
   int          err_count = 0;
   logic [31:0] lcg_state = 32'h2c95c125;
   logic        capture_on = 1'b0;
   logic [15:0] words_q[$];
   logic        frames_q[$];

   dac_tx_top u_dac_tx_top
   (
      .tx_clk_1x (tx_clk_1x), .tx_clk_2x (tx_clk_2x), .reset (reset),
      .i_wr_stb (i_wr_stb), .i_wr_addr (i_wr_addr), .i_wr_data (i_wr_data),
      .i_i (i_i), .i_q (i_q),
      .o_tx_clk_p (o_tx_clk_p), .o_tx_clk_n (o_tx_clk_n),
      .o_tx_frame_p (o_tx_frame_p), .o_tx_frame_n (o_tx_frame_n),
      .o_tx_d_p (o_tx_d_p), .o_tx_d_n (o_tx_d_n)
   );

   // 2x clock, period 5 in whole time units
   always
   begin
      #3 tx_clk_2x = 1'b1;
      #2 tx_clk_2x = 1'b0;
   end

   // 1x clock edges sit on 2x rising edges
   always @(posedge tx_clk_2x) tx_clk_1x <= ~tx_clk_1x;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Substitute, then swap, then negate
   function automatic logic [31:0] expected_pair(input logic [15:0] ii, input logic [15:0] qq,
                                                 input logic [3:0] ctrl, input logic [31:0] pat);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] t;
      a = ctrl[3] ? pat[15:0] : ii;
      b = ctrl[3] ? pat[31:16] : qq;
      if (ctrl[0])
      begin
         t = a;
         a = b;
         b = t;
      end
      if (ctrl[1]) a = 16'd0 - a;
      if (ctrl[2]) b = 16'd0 - b;
      return {a, b};
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         err_count++;
         $display("error %s %s: expected %h actual %h", cur_name, what, exp, act);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic stop_run(input string msg);
      $display("%s in %s", msg, cur_name);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
      @(negedge tx_clk_1x);
      i_wr_stb  = 1'b1;
      i_wr_addr = addr;
      i_wr_data = data;
      @(negedge tx_clk_1x);
      i_wr_stb  = 1'b0;
   endtask

   // Rebuild words from both halves of each 2x cycle, mid-half
   initial
   begin
      logic [7:0] hi;
      logic       fr;
      forever
      begin
         @(posedge tx_clk_2x);
         #1;
         hi = o_tx_d_p;
         fr = o_tx_frame_p;
         check_value("d_n high half", {24'd0, ~o_tx_d_p}, {24'd0, o_tx_d_n});
         check_value("frame_n", {31'd0, ~o_tx_frame_p}, {31'd0, o_tx_frame_n});
         // Forwarded clock is high in the first half
         check_value("clk pins high half", 32'd2, {30'd0, o_tx_clk_p, o_tx_clk_n});
         @(negedge tx_clk_2x);
         #1;
         check_value("d_n low half", {24'd0, ~o_tx_d_p}, {24'd0, o_tx_d_n});
         check_value("clk pins low half", 32'd1, {30'd0, o_tx_clk_p, o_tx_clk_n});
         if (capture_on)
         begin
            words_q.push_back({hi, o_tx_d_p});
            frames_q.push_back(fr);
         end
      end
   end

   task automatic run_case(input int k);
      logic [31:0] exp_q[$];
      logic [31:0] pairs[$];
      logic [15:0] last_i;
      logic        have_i;
      logic        seen_low;
      int          run_len;
      int          threes;
      int          odd;
      int          p;
      int          skipped;
      logic [31:0] r;
      cur_name = tname[k];
      reg_write(REG_TEST, tpat[k]);
      reg_write(REG_CTRL, {28'd0, tctrl[k]});
      repeat (4) @(negedge tx_clk_1x);
      words_q.delete();
      frames_q.delete();
      capture_on = 1'b1;
      for (int j = 0; j < tcount[k]; j++)
      begin
         lcg_state = lcg_next(lcg_state);
         r = lcg_state;
         @(negedge tx_clk_1x);
         i_i = r[31:16];
         i_q = r[15:0];
         exp_q.push_back(expected_pair(r[31:16], r[15:0], tctrl[k], tpat[k]));
         i_wr_stb  = tsync[k] && (j == tcount[k] / 2);
         i_wr_addr = REG_SYNC;
      end
      @(negedge tx_clk_1x);
      i_i = '0;
      i_q = '0;
      i_wr_stb = 1'b0;
      repeat (12) @(negedge tx_clk_1x);
      capture_on = 1'b0;
      // Pair each Q word with the I word before it and measure frame runs
      have_i = 1'b0;
      seen_low = 1'b0;
      run_len = 0;
      threes = 0;
      odd = 0;
      for (int w = 0; w < words_q.size(); w++)
      begin
         if (frames_q[w])
         begin
            last_i = words_q[w];
            have_i = 1'b1;
            run_len++;
         end
         else
         begin
            if (have_i) pairs.push_back({last_i, words_q[w]});
            if (seen_low && run_len == 3) threes++;
            else if (seen_low && run_len != 1) odd++;
            run_len = 0;
            seen_low = 1'b1;
         end
      end
      check_value("three-word frame runs", {31'd0, tsync[k]}, threes);
      check_value("other frame run lengths", 0, odd);
      // Align on the first expected pair, then compare in order
      p = 0;
      while (p < pairs.size() && pairs[p] !== exp_q[0]) p++;
      if (p == pairs.size()) stop_run("first expected pair never reached the pins");
      skipped = 0;
      for (int e = 0; e < tcount[k]; e++)
      begin
         if (p >= pairs.size()) stop_run("output stream ended before all samples came out");
         // Sync drops the Q slot of one sample
         if (tsync[k] && skipped == 0 && pairs[p] !== exp_q[e]) skipped = 1;
         else
         begin
            check_value("pair", exp_q[e], pairs[p]);
            p++;
         end
      end
      check_value("dropped pairs", {31'd0, tsync[k]}, skipped);
   endtask

   // One column per field, one entry per case in the same order
   task automatic load_table();
      tname  = '{"pass_through", "swap", "neg_i", "neg_q", "neg_iq", "swap_neg_all",
                 "test_pattern", "test_swap_neg", "frame_sync"};
      tctrl  = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h6, 4'h7, 4'h8, 4'hf, 4'h0};
      tpat   = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
                 32'h8000_1234, 32'h8000_1234, 32'h0};
      tsync  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
      tcount = '{24, 16, 16, 16, 16, 16, 12, 12, 24};
   endtask

   // Watchdog scaled from the table's sample counts
   initial
   begin
      int total;
      #1;
      total = 0;
      for (int k = 0; k < NCASE; k++) total += tcount[k];
      #(total * 10 + NCASE * 300 + 2000);
      $display("timeout, the run did not finish in time");
      $display("test failed");
      $fatal(1);
   end

   initial
   begin
      load_table();
      repeat (8) @(negedge tx_clk_1x);
      #1;
      check_value("data in reset", 0, {24'd0, o_tx_d_p});
      check_value("frame in reset", 0, {31'd0, o_tx_frame_p});
      repeat (2) @(negedge tx_clk_1x);
      reset = 1'b0;
      // Pattern loaded with test mode off, zero samples keep the lane at zero
      reg_write(REG_TEST, 32'h5a5a_a5a5);
      // Address 8 lands on the control register if bit 3 were ignored
      for (int n = 0; n < 2; n++)
      begin
         if (n == 1) reg_write(4'h8, 32'hffff_ffff);
         repeat (6) @(negedge tx_clk_1x);
         repeat (8)
         begin
            @(posedge tx_clk_2x);
            #1;
            check_value("idle data", 0, {24'd0, o_tx_d_p});
         end
      end
      for (int k = 0; k < NCASE; k++) run_case(k);
      if (err_count != 0)
      begin
         $display("test failed");
         $fatal(1);
      end
      else
      begin
         $display("test passed");
         $finish;
      end
   end

endmodule

`default_nettype wire
